/* div_ctrl.sv */
`timescale 1ns/1ns

module div_ctrl (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  logic                     in_valid,
	output logic                     in_ready,
	output logic                     start,
	input  logic                     done,
	input  logic [div_pkg::xlen-1:0] fixed_result,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic [div_pkg::xlen-1:0] out_result
);
	div_pkg::ctrl_state_e state;
	div_pkg::ctrl_state_e state_next;

	always_comb begin
		state_next = state;
		case (state)
			div_pkg::idle: begin
				if (in_valid) begin
					state_next = div_pkg::busy;
				end
			end
			div_pkg::busy: begin
				if (done) begin
					state_next = div_pkg::done;
				end
			end
			div_pkg::done: begin
				if (out_ready) begin
					state_next = div_pkg::idle; // result taken
				end
			end
			default: state_next = div_pkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			state <= div_pkg::idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (state == div_pkg::busy && done) begin
			out_result <= fixed_result; // held until transfer
		end
	end

	assign in_ready  = (state == div_pkg::idle);
	assign start     = in_ready && in_valid;
	assign out_valid = (state == div_pkg::done);

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_result));

	// the core reports a result only while an operation is in flight
	assert property (@(posedge clk) disable iff (!rst_n) done |-> state == div_pkg::busy);

endmodule

/* div_iter_core.sv */
`timescale 1ns/1ns

module div_iter_core (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  logic                     start,
	input  logic [div_pkg::xlen-1:0] mag_a,
	input  logic [div_pkg::xlen-1:0] mag_b,
	input  logic                     is_word,
	input  logic                     neg_quot,
	input  logic                     neg_rem,
	input  logic                     div_zero,
	input  logic                     sign_ovf,
	input  div_pkg::div_op_e         op_in,
	output logic [div_pkg::xlen-1:0] raw_quot,
	output logic [div_pkg::xlen-1:0] raw_rem,
	output logic                     done,
	output div_pkg::div_op_e         op_out,
	output logic                     is_word_q,
	output logic                     neg_quot_q,
	output logic                     neg_rem_q,
	output logic                     div_zero_q,
	output logic                     sign_ovf_q
);
	localparam int w     = div_pkg::xlen;
	localparam int cnt_w = $clog2(div_pkg::xlen);

	logic [2*w-1:0]   part_rem;  // remainder in upper half, dividend bits below
	logic [w-1:0]     divisor_q;
	logic [w-1:0]     quot;
	logic [w:0]       part_sub;  // bit w is the borrow
	logic [cnt_w-1:0] cnt;
	logic             running;
	logic             last_iter;
	logic             done_q;

	assign part_sub  = part_rem[2*w-1:w-1] - {1'b0, divisor_q};
	assign last_iter = (cnt == (is_word_q ? cnt_w'(w / 2 - 1) : cnt_w'(w - 1)));

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			running <= 1'b0;
			cnt     <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= running && last_iter; // one cycle after the final shift
			if (start) begin
				running <= 1'b1;
				cnt     <= '0;
			end else if (running) begin
				cnt <= cnt + 1'b1;
				if (last_iter) begin
					running <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			part_rem   <= {{w{1'b0}}, mag_a};
			divisor_q  <= mag_b;
			quot       <= '0;
			op_out     <= op_in;
			is_word_q  <= is_word;
			neg_quot_q <= neg_quot;
			neg_rem_q  <= neg_rem;
			div_zero_q <= div_zero;
			sign_ovf_q <= sign_ovf;
		end else if (running) begin
			if (part_sub[w]) begin
				part_rem <= {part_rem[2*w-2:0], 1'b0}; // restore, plain shift
			end else begin
				part_rem <= {part_sub[w-1:0], part_rem[w-2:0], 1'b0};
			end
			quot <= {quot[w-2:0], ~part_sub[w]};
		end
	end

	assign raw_quot = quot;
	assign raw_rem  = part_rem[2*w-1:w];
	assign done     = done_q;

	// the controller may only load a new operation once the core is free
	assert property (@(posedge clk) disable iff (!rst_n) running |-> !start);

	assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

endmodule

/* div_operand_prep.sv */
`timescale 1ns/1ns

module div_operand_prep (
	input  div_pkg::div_op_e         op,
	input  logic [div_pkg::xlen-1:0] a,
	input  logic [div_pkg::xlen-1:0] b,
	output logic [div_pkg::xlen-1:0] mag_a,
	output logic [div_pkg::xlen-1:0] mag_b,
	output logic                     is_word,
	output logic                     neg_quot,
	output logic                     neg_rem,
	output logic                     div_zero,
	output logic                     sign_ovf
);
	localparam int w  = div_pkg::xlen;
	localparam int hw = div_pkg::xlen / 2;

	logic          is_signed;
	logic          sign_a;
	logic          sign_b;
	logic [hw-1:0] abs_a_w;
	logic [hw-1:0] abs_b_w;
	logic [w-1:0]  abs_a;
	logic [w-1:0]  abs_b;
	logic          ovf_w;
	logic          ovf_d;

	assign is_word   = op inside {div_pkg::divw, div_pkg::divuw, div_pkg::remw, div_pkg::remuw};
	assign is_signed = op inside {div_pkg::div, div_pkg::rem, div_pkg::divw, div_pkg::remw};

	assign sign_a = is_word ? a[hw-1] : a[w-1]; // sign bit at the operation width
	assign sign_b = is_word ? b[hw-1] : b[w-1];

	assign abs_a_w = (is_signed && a[hw-1]) ? -a[hw-1:0] : a[hw-1:0];
	assign abs_b_w = (is_signed && b[hw-1]) ? -b[hw-1:0] : b[hw-1:0];
	assign abs_a   = (is_signed && a[w-1]) ? -a : a;
	assign abs_b   = (is_signed && b[w-1]) ? -b : b;

	// word dividend sits in the upper half so 32 shifts bring it down
	assign mag_a = is_word ? {abs_a_w, {hw{1'b0}}} : abs_a;
	assign mag_b = is_word ? {{hw{1'b0}}, abs_b_w} : abs_b;

	assign div_zero = is_word ? (b[hw-1:0] == '0) : (b == '0);

	assign ovf_w = (a[hw-1:0] == {1'b1, {(hw - 1){1'b0}}}) && (b[hw-1:0] == '1);
	assign ovf_d = (a == {1'b1, {(w - 1){1'b0}}}) && (b == '1);
	assign sign_ovf = is_signed && (is_word ? ovf_w : ovf_d); // most negative / -1

	assign neg_quot = is_signed && (sign_a ^ sign_b); // signs differ
	assign neg_rem  = is_signed && sign_a;             // remainder follows dividend

endmodule

/* div_pkg.sv */
package div_pkg;

	localparam int xlen = 64; // operand and result width of rv64

	// m-extension divide opcodes, word forms have bit 2 set
	typedef enum logic [2:0] {
		div   = 3'd0,
		divu  = 3'd1,
		rem   = 3'd2,
		remu  = 3'd3,
		divw  = 3'd4,
		divuw = 3'd5,
		remw  = 3'd6,
		remuw = 3'd7
	} div_op_e;

	// handshake FSM of div_ctrl
	typedef enum logic [1:0] {
		idle = 2'd0, // waiting for an operation
		busy = 2'd1, // core iterating
		done = 2'd2  // result held for the consumer
	} ctrl_state_e;

endpackage

/* div_result_fix.sv */
`timescale 1ns/1ns

module div_result_fix (
	input  div_pkg::div_op_e         op,
	input  logic                     is_word,
	input  logic                     neg_quot,
	input  logic                     neg_rem,
	input  logic                     div_zero,
	input  logic                     sign_ovf,
	input  logic [div_pkg::xlen-1:0] raw_quot,
	input  logic [div_pkg::xlen-1:0] raw_rem,
	output logic [div_pkg::xlen-1:0] fixed_result
);
	localparam int w  = div_pkg::xlen;
	localparam int hw = div_pkg::xlen / 2;

	logic         is_rem;
	logic [w-1:0] quot_s;
	logic [w-1:0] rem_s;
	logic [w-1:0] min_val;
	logic [w-1:0] res;

	assign is_rem = op inside {div_pkg::rem, div_pkg::remu, div_pkg::remw, div_pkg::remuw};

	assign quot_s = neg_quot ? -raw_quot : raw_quot;
	assign rem_s  = neg_rem ? -raw_rem : raw_rem; // also the dividend on a zero divisor

	// most negative value at the operation width
	assign min_val = is_word ? {{hw{1'b0}}, 1'b1, {(hw - 1){1'b0}}}
	                         : {1'b1, {(w - 1){1'b0}}};

	always_comb begin
		if (div_zero) begin
			res = is_rem ? rem_s : '1;        // quotient all ones
		end else if (sign_ovf) begin
			res = is_rem ? '0 : min_val;
		end else begin
			res = is_rem ? rem_s : quot_s;
		end
	end

	assign fixed_result = is_word ? {{hw{res[hw-1]}}, res[hw-1:0]} : res; // sign-extend words

endmodule

/* div_unit.f */
+incdir+.
div_pkg.sv
div_operand_prep.sv
div_iter_core.sv
div_result_fix.sv
div_ctrl.sv
div_unit.sv
tb_div_unit.sv

/* div_unit.sv */
`timescale 1ns/1ns

module div_unit (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  logic                     in_valid,
	output logic                     in_ready,
	input  div_pkg::div_op_e         in_op,
	input  logic [div_pkg::xlen-1:0] in_a,
	input  logic [div_pkg::xlen-1:0] in_b,
	output logic                     out_valid,
	input  logic                     out_ready,
	output logic [div_pkg::xlen-1:0] out_result
);
	logic [div_pkg::xlen-1:0] mag_a;
	logic [div_pkg::xlen-1:0] mag_b;
	logic                     is_word;
	logic                     neg_quot;
	logic                     neg_rem;
	logic                     div_zero;
	logic                     sign_ovf;
	logic                     start;
	logic                     done;
	logic [div_pkg::xlen-1:0] raw_quot;
	logic [div_pkg::xlen-1:0] raw_rem;
	div_pkg::div_op_e         op_q;
	logic                     is_word_q;
	logic                     neg_quot_q;
	logic                     neg_rem_q;
	logic                     div_zero_q;
	logic                     sign_ovf_q;
	logic [div_pkg::xlen-1:0] fixed_result;

	div_operand_prep i_prep (
		.op       (in_op),
		.a        (in_a),
		.b        (in_b),
		.mag_a    (mag_a),
		.mag_b    (mag_b),
		.is_word  (is_word),
		.neg_quot (neg_quot),
		.neg_rem  (neg_rem),
		.div_zero (div_zero),
		.sign_ovf (sign_ovf)
	);

	div_iter_core i_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.start      (start),
		.mag_a      (mag_a),
		.mag_b      (mag_b),
		.is_word    (is_word),
		.neg_quot   (neg_quot),
		.neg_rem    (neg_rem),
		.div_zero   (div_zero),
		.sign_ovf   (sign_ovf),
		.op_in      (in_op),
		.raw_quot   (raw_quot),
		.raw_rem    (raw_rem),
		.done       (done),
		.op_out     (op_q),
		.is_word_q  (is_word_q),
		.neg_quot_q (neg_quot_q),
		.neg_rem_q  (neg_rem_q),
		.div_zero_q (div_zero_q),
		.sign_ovf_q (sign_ovf_q)
	);

	div_result_fix i_fix (
		.op           (op_q),
		.is_word      (is_word_q),
		.neg_quot     (neg_quot_q),
		.neg_rem      (neg_rem_q),
		.div_zero     (div_zero_q),
		.sign_ovf     (sign_ovf_q),
		.raw_quot     (raw_quot),
		.raw_rem      (raw_rem),
		.fixed_result (fixed_result)
	);

	div_ctrl i_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush        (flush),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.start        (start),
		.done         (done),
		.fixed_result (fixed_result),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_result   (out_result)
	);

endmodule

/* tb_div_model.svh */
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// one xorshift64 step that never returns zero for a nonzero input
function automatic logic [63:0] xorshift64(input logic [63:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 7);
	x = x ^ (x << 17);
	return x;
endfunction

// rv64 m-extension divide results with zero divisor and overflow handled first
function automatic logic [63:0] model_div(input div_pkg::div_op_e op, input logic [63:0] a,
		input logic [63:0] b);
	logic [63:0] mn;
	logic [31:0] aw;
	logic [31:0] bw;
	logic [31:0] rw;
	logic [63:0] r;
	mn = 64'h8000_0000_0000_0000;
	aw = a[31:0];
	bw = b[31:0];
	r  = '0;
	rw = '0;
	case (op)
		div_pkg::div: begin
			if (b == '0) r = '1;
			else if (a == mn && b == '1) r = mn;
			else r = $signed(a) / $signed(b); // truncates toward zero
		end
		div_pkg::rem: begin
			if (b == '0) r = a;
			else if (a == mn && b == '1) r = '0;
			else r = $signed(a) % $signed(b); // sign of the dividend
		end
		div_pkg::divu: r = (b == '0) ? '1 : a / b;
		div_pkg::remu: r = (b == '0) ? a : a % b;
		div_pkg::divw: begin
			if (bw == '0) rw = '1;
			else if (aw == 32'h8000_0000 && bw == '1) rw = aw;
			else rw = $signed(aw) / $signed(bw);
		end
		div_pkg::remw: begin
			if (bw == '0) rw = aw;
			else if (aw == 32'h8000_0000 && bw == '1) rw = '0;
			else rw = $signed(aw) % $signed(bw);
		end
		div_pkg::divuw: rw = (bw == '0) ? '1 : aw / bw;
		default: rw = (bw == '0) ? aw : aw % bw; // remuw
	endcase
	if (op inside {div_pkg::divw, div_pkg::divuw, div_pkg::remw, div_pkg::remuw}) begin
		r = {{32{rw[31]}}, rw}; // word results are sign-extended
	end
	return r;
endfunction

`endif

/* tb_div_unit.sv */
`timescale 1ns/1ns

module tb_div_unit;
	localparam logic [63:0] seed       = 64'd9995;
	localparam int          n_full     = 300;
	localparam int          n_word     = 200;
	localparam int          n_bp       = 40;
	localparam int          wait_limit = 200; // cycles allowed per wait loop

	logic             clk;
	logic             rst_n;
	logic             flush;
	logic             in_valid;
	logic             in_ready;
	div_pkg::div_op_e in_op;
	logic [63:0]      in_a;
	logic [63:0]      in_b;
	logic             out_valid;
	logic             out_ready;
	logic [63:0]      out_result;
	logic [63:0]      rnd_state;
	int               errors;
	int               tests;
	int               failed_tests;

	`include "tb_div_model.svh"

	div_unit i_div_unit (
		.clk        (clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [63:0] next_rand();
		rnd_state = xorshift64(rnd_state);
		return rnd_state;
	endfunction

	task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
		if (act !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, act, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int start_err);
		tests++;
		if (errors != start_err) failed_tests++;
		$display("test %-10s %s, %0d errors", name, (errors == start_err) ? "ok" : "FAILED",
			errors - start_err);
	endtask

	task automatic pick_operands(input logic word, output div_pkg::div_op_e op,
			output logic [63:0] a, output logic [63:0] b);
		logic [63:0] r;
		r  = next_rand();
		op = div_pkg::div_op_e'({word, r[1:0]});
		a  = next_rand();
		b  = next_rand() >> r[7:2]; // spread the divisor size
		if (r[10:8] == 3'd0) begin
			case (r[12:11])
				2'd0: b = word ? {b[63:32], 32'd0} : '0;
				2'd1: begin // most negative by -1
					a = word ? {a[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
					b = word ? {b[63:32], 32'hffff_ffff} : '1;
				end
				default: begin
					a = {{56{r[13]}}, r[63:56]};
					b = {{60{r[14]}}, r[55:52]};
				end
			endcase
		end
	endtask

	task automatic accept_op(input div_pkg::div_op_e op, input logic [63:0] a,
			input logic [63:0] b);
		int n;
		@(posedge clk);
		in_valid <= 1'b1;
		in_op    <= op;
		in_a     <= a;
		in_b     <= b;
		n = 0;
		@(negedge clk);
		while (!in_ready) begin
			n++;
			if (n > wait_limit) abort_run("timeout waiting for in_ready");
			@(negedge clk);
		end
		@(posedge clk); // acceptance edge
		in_valid <= 1'b0;
	endtask

	// full transaction, latency counts the acceptance edge as the first
	task automatic run_op(input div_pkg::div_op_e op, input logic [63:0] a,
			input logic [63:0] b, input logic bp);
		int          lat;
		logic [63:0] held;
		logic [63:0] r;
		logic        taken;
		accept_op(op, a, b);
		r = next_rand();
		out_ready <= bp ? r[0] : 1'b1;
		lat = 1;
		@(negedge clk);
		while (!out_valid) begin
			if (lat > wait_limit) abort_run("timeout waiting for out_valid");
			@(posedge clk);
			lat++;
			@(negedge clk);
		end
		check_val("latency", lat, (op inside {div_pkg::divw, div_pkg::divuw, div_pkg::remw,
			div_pkg::remuw}) ? 34 : 66);
		check_val("out_result", out_result, model_div(op, a, b));
		held  = out_result;
		taken = 1'b0;
		lat   = 0;
		while (!taken) begin
			check_val("out_result", out_result, held);
			check_val("in_ready", in_ready, 1'b0);
			check_val("out_valid", out_valid, 1'b1);
			taken = out_ready;
			lat++;
			if (lat > wait_limit) abort_run("timeout waiting for the result transfer");
			r = next_rand();
			@(posedge clk);
			out_ready <= bp ? r[0] : 1'b1;
			@(negedge clk);
		end
		check_val("out_valid", out_valid, 1'b0);
	endtask

	task automatic flush_after(input int cycles, input logic expect_valid);
		accept_op(div_pkg::div, 64'd1000, 64'd7);
		out_ready <= 1'b0;
		repeat (cycles) @(posedge clk);
		@(negedge clk);
		check_val("out_valid", out_valid, expect_valid);
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		check_val("out_valid", out_valid, 1'b0);
		check_val("in_ready", in_ready, 1'b1);
		repeat (70) @(posedge clk); // dropped op must not complete later
		@(negedge clk);
		check_val("out_valid", out_valid, 1'b0);
	endtask

	initial begin
		div_pkg::div_op_e op;
		logic [63:0]      a;
		logic [63:0]      b;
		int               start_err;
		rst_n        = 1'b0;
		flush        = 1'b0;
		in_valid     = 1'b0;
		in_op        = div_pkg::div;
		in_a         = '0;
		in_b         = '0;
		out_ready    = 1'b0;
		rnd_state    = seed;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		start_err = errors;
		check_val("in_ready", in_ready, 1'b1);
		check_val("out_valid", out_valid, 1'b0);
		report_test("reset", start_err);

		start_err = errors;
		for (int i = 0; i < n_full; i++) begin
			pick_operands(1'b0, op, a, b);
			run_op(op, a, b, 1'b0);
		end
		report_test("full_width", start_err);

		start_err = errors;
		for (int i = 0; i < n_word; i++) begin
			pick_operands(1'b1, op, a, b);
			run_op(op, a, b, 1'b0);
		end
		report_test("word", start_err);

		start_err = errors;
		for (int k = 0; k < 8; k++) begin
			op = div_pkg::div_op_e'(k);
			run_op(op, 64'hfedc_ba98_7654_3210, 64'h0, 1'b0);
			run_op(op, 64'h0123_4567_89ab_cdef, 64'habcd_0000_0000_0000, 1'b0);
			run_op(op, 64'h8000_0000_0000_0000, '1, 1'b0);
			run_op(op, 64'h1234_5678_8000_0000, 64'h0000_0001_ffff_ffff, 1'b0);
		end
		report_test("corners", start_err);

		start_err = errors;
		for (int i = 0; i < n_bp; i++) begin
			a = next_rand();
			pick_operands(a[5], op, a, b);
			run_op(op, a, b, 1'b1);
		end
		report_test("backpress", start_err);

		start_err = errors;
		flush_after(20, 1'b0); // busy
		flush_after(70, 1'b1); // result held
		for (int i = 0; i < 3; i++) begin
			pick_operands(i[0], op, a, b);
			run_op(op, a, b, 1'b0);
		end
		report_test("flush", start_err);

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
